// File: vlog.f
+incdir+dv
hdl/core_pkg.sv
hdl/issue_if.sv
hdl/operand_bypass.sv
hdl/alu.sv
hdl/alu_exec_unit.sv
dv/tb_clk_gen.sv
dv/tb_alu_exec.sv

// File: Bender.yml
package:
  name: alu_exec_unit

sources:
  - files:
      - hdl/core_pkg.sv
      - hdl/issue_if.sv
      - hdl/operand_bypass.sv
      - hdl/alu.sv
      - hdl/alu_exec_unit.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_alu_exec.sv

// File: dv/alu_exec_vectors.svh
`ifndef ALU_EXEC_VECTORS_SVH
`define ALU_EXEC_VECTORS_SVH

// One row per issue cycle, result expected one edge later
typedef struct {
    logic         issue_valid;
    alu_op_t      op;
    preg_tag_t    dst;
    rob_tag_t     rob;
    src_operand_t src1;
    src_operand_t src2;
    logic         cdb_valid;
    preg_tag_t    cdb_tag;
    word_t        cdb_value;
    logic         exp_ready;
    logic         exp_valid;
    word_t        exp_value;
    alu_flags_t   exp_flags;
} vec_row_t;

// Columns: valid, opcode, func, dst, src1 r/t/v, src2 r/t/v, cdb v/t/val,
// expected ready, result valid, value, flags (ZNVC)
function automatic vec_row_t full_row(logic v, logic [5:0] opc, logic [5:0] fn,
        preg_tag_t dst, logic r1, preg_tag_t t1, word_t v1, logic r2, preg_tag_t t2,
        word_t v2, logic cv, preg_tag_t ct, word_t cval, logic er, logic ev,
        word_t eval, alu_flags_t ef);
    vec_row_t r;
    r = '{v, '{opc, fn}, dst, dst + 6'd7, '{r1, t1, v1}, '{r2, t2, v2},
          cv, ct, cval, er, ev, eval, ef};
    return r;
endfunction

// Both operands ready, no CDB traffic
function automatic vec_row_t ready_row(logic [5:0] opc, logic [5:0] fn, preg_tag_t dst,
        word_t a, word_t b, word_t eval, alu_flags_t ef);
    return full_row(1, opc, fn, dst, 1, 0, a, 1, 0, b, 0, 0, 0, 1, 1, eval, ef);
endfunction

task automatic load_table(ref vec_row_t q[$]);
    // ==============================
    // Operations and flags
    // ==============================
    q.push_back(ready_row(OP_RTYPE, FN_ADD, 1, 32'h5, 32'h7, 32'hC, 4'b0000));
    q.push_back(ready_row(OP_RTYPE, FN_SUB, 2, 32'h7, 32'h5, 32'h2, 4'b0001));
    q.push_back(ready_row(OP_RTYPE, FN_SUB, 3, 32'h5, 32'h7, 32'hFFFFFFFE, 4'b0100));
    q.push_back(ready_row(OP_RTYPE, FN_ADD, 4, 32'h7FFFFFFF, 32'h1, 32'h80000000, 4'b0110));
    q.push_back(ready_row(OP_RTYPE, FN_ADD, 5, 32'hFFFFFFFF, 32'h1, 32'h0, 4'b1001));
    q.push_back(ready_row(OP_RTYPE, FN_SUB, 6, 32'h80000000, 32'h1, 32'h7FFFFFFF, 4'b0011));
    q.push_back(ready_row(OP_RTYPE, FN_AND, 7, 32'hF0F0F0F0, 32'hFF00FF00, 32'hF000F000, 4'b0100));
    q.push_back(ready_row(OP_RTYPE, FN_ORR, 8, 32'h0F0F0000, 32'hF0, 32'h0F0F00F0, 4'b0000));
    q.push_back(ready_row(OP_RTYPE, FN_EOR, 9, 32'hAAAA5555, 32'hAAAA5555, 32'h0, 4'b1000));
    q.push_back(ready_row(OP_RTYPE, FN_NEG, 10, 32'h1, 32'h0, 32'hFFFFFFFF, 4'b0100));
    q.push_back(ready_row(OP_RTYPE, FN_CMP, 11, 32'h3, 32'h3, 32'h0, 4'b1001));
    // Shift amount uses the low 5 bits only
    q.push_back(ready_row(OP_RTYPE, FN_LSL, 12, 32'h1, 32'h24, 32'h10, 4'b0000));
    q.push_back(ready_row(OP_RTYPE, FN_LSR, 13, 32'h80000000, 32'h1F, 32'h1, 4'b0000));
    q.push_back(ready_row(OP_RTYPE, FN_LSLI, 14, 32'h3, 32'h2, 32'hC, 4'b0000));
    q.push_back(ready_row(OP_RTYPE, FN_LSRI, 15, 32'hF0, 32'h4, 32'hF, 4'b0000));
    q.push_back(ready_row(OP_RTYPE, FN_RET, 16, 32'h1234, 32'h0, 32'h1234, 4'b0000));
    q.push_back(ready_row(OP_RTYPE, 6'h3F, 17, 32'h5, 32'h5, 32'h0, 4'b1000));
    q.push_back(ready_row(OP_ADDI, 6'h0, 18, 32'hA, 32'hFFFFFFFF, 32'h9, 4'b0001));
    q.push_back(ready_row(OP_SUBI, 6'h0, 19, 32'hA, 32'h3, 32'h7, 4'b0001));
    q.push_back(ready_row(OP_ANDI, 6'h0, 20, 32'hFF, 32'hF, 32'hF, 4'b0000));
    q.push_back(ready_row(OP_ORI, 6'h0, 21, 32'hF0, 32'hF, 32'hFF, 4'b0000));
    q.push_back(ready_row(OP_EORI, 6'h0, 22, 32'hFF, 32'hF, 32'hF0, 4'b0000));
    // ==============================
    // Capture, bypass, non-ALU ops
    // ==============================
    q.push_back(full_row(1, OP_RTYPE, FN_ADD, 30, 0, 40, 32'hDEAD, 1, 0, 32'h5,
                         1, 40, 32'h64, 1, 1, 32'h69, 4'b0000));
    q.push_back(full_row(1, OP_RTYPE, FN_ADD, 31, 0, 41, 32'hDEAD, 1, 0, 32'h5,
                         1, 42, 32'h64, 0, 0, 32'h0, 4'b0000));
    q.push_back(full_row(1, OP_RTYPE, FN_ADD, 50, 1, 0, 32'h10, 1, 0, 32'h20,
                         0, 0, 32'h0, 1, 1, 32'h30, 4'b0000));
    // Bypass beats a CDB carrying the same tag
    q.push_back(full_row(1, OP_RTYPE, FN_ADD, 51, 0, 50, 32'hDEAD, 1, 0, 32'h1,
                         1, 50, 32'h999, 1, 1, 32'h31, 4'b0000));
    q.push_back(full_row(1, OP_RTYPE, FN_SUB, 52, 1, 0, 32'h40, 0, 51, 32'hDEAD,
                         0, 0, 32'h0, 1, 1, 32'hF, 4'b0001));
    q.push_back(full_row(1, 6'h3F, 6'h0, 53, 1, 0, 32'h1, 1, 0, 32'h1,
                         0, 0, 32'h0, 1, 0, 32'h0, 4'b0000));
    q.push_back(full_row(0, OP_RTYPE, FN_ADD, 54, 1, 0, 32'h1, 1, 0, 32'h1,
                         0, 0, 32'h0, 1, 0, 32'h0, 4'b0000));
endtask

`endif

// File: dv/tb_alu_exec.sv
`timescale 1ns/10ps
`default_nettype none

module tb_alu_exec
    import core_pkg::*;
;

    localparam int NUM_TABLE_OPS = 22;
    localparam int NUM_RANDOM    = 64;

    logic clk, reset;
    logic issue_valid, issue_ready, issue_src1_ready, issue_src2_ready, cdb_valid;
    alu_op_t issue_op;
    preg_tag_t issue_dst_tag, issue_src1_tag, issue_src2_tag, cdb_tag;
    rob_tag_t issue_rob_tag;
    word_t issue_src1_value, issue_src2_value, cdb_value;
    logic result_valid;
    preg_tag_t result_tag;
    word_t result_value;
    rob_tag_t result_rob_tag;
    alu_flags_t result_flags;

    int errors;
    int failed_tests;

    `include "alu_exec_vectors.svh"

    vec_row_t rows[$];

    tb_clk_gen #(.PERIOD(100.0), .RESET_CYCLES(2)) i_clk_gen (.clk(clk), .reset(reset));

    alu_exec_unit #(.XLEN(XLEN), .PHYS_W(LOG2_PREGS)) i_alu_exec_unit (.*);

    // ==============================
    // Compare tasks
    // ==============================
    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flags(string name, alu_flags_t got, alu_flags_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_tag(string name, preg_tag_t got, preg_tag_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_rob(string name, rob_tag_t got, rob_tag_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Expected result from the operation and flag rules
    function automatic void model_alu(alu_op_t op, word_t a, word_t b,
                                      output word_t val, output alu_flags_t fl);
        longint sa;
        longint sb;
        longint s;
        logic [32:0] wide;
        sa = $signed(a);
        sb = $signed(b);
        fl = '0;
        val = '0;
        if (op.opcode == OP_ADDI || (op.opcode == OP_RTYPE && op.func == FN_ADD)) begin
            wide = {1'b0, a} + {1'b0, b};
            val = wide[31:0];
            s = sa + sb;
            fl.carry = wide[32];
            fl.overflow = (s > 64'sh7FFFFFFF) || (s < -64'sh80000000);
        end else if (op.opcode == OP_SUBI || (op.opcode == OP_RTYPE &&
                     (op.func == FN_SUB || op.func == FN_CMP))) begin
            val = a - b;
            s = sa - sb;
            fl.carry = (a >= b);
            fl.overflow = (s > 64'sh7FFFFFFF) || (s < -64'sh80000000);
        end else if (op.opcode == OP_ANDI || (op.opcode == OP_RTYPE && op.func == FN_AND))
            val = a & b;
        else if (op.opcode == OP_ORI || (op.opcode == OP_RTYPE && op.func == FN_ORR))
            val = a | b;
        else if (op.opcode == OP_EORI || (op.opcode == OP_RTYPE && op.func == FN_EOR))
            val = a ^ b;
        else if (op.func == FN_NEG)
            val = -a;
        else if (op.func == FN_LSL || op.func == FN_LSLI)
            val = a << b[4:0];
        else if (op.func == FN_LSR || op.func == FN_LSRI)
            val = a >> b[4:0];
        else if (op.func == FN_RET)
            val = a;
        fl.zero = (val == 0);
        fl.negative = val[31];
    endfunction

    task automatic drive_row(vec_row_t r);
        issue_valid      <= r.issue_valid;
        issue_op         <= r.op;
        issue_dst_tag    <= r.dst;
        issue_rob_tag    <= r.rob;
        issue_src1_ready <= r.src1.ready;
        issue_src1_tag   <= r.src1.tag;
        issue_src1_value <= r.src1.value;
        issue_src2_ready <= r.src2.ready;
        issue_src2_tag   <= r.src2.tag;
        issue_src2_value <= r.src2.value;
        cdb_valid        <= r.cdb_valid;
        cdb_tag          <= r.cdb_tag;
        cdb_value        <= r.cdb_value;
    endtask

    task automatic check_result(vec_row_t r);
        check_bit("result_valid", result_valid, r.exp_valid);
        if (r.exp_valid) begin
            check_word("result_value", result_value, r.exp_value);
            check_flags("result_flags", result_flags, r.exp_flags);
            check_tag("result_tag", result_tag, r.dst);
            check_rob("result_rob_tag", result_rob_tag, r.rob);
        end
    endtask

    // Overall guard against a stuck run
    initial begin
        #200us;
        $display("Simulation timed out");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        vec_row_t r;
        vec_row_t idle;
        int n;
        int err_before;
        errors = 0;
        failed_tests = 0;
        void'($urandom(32'h739));
        issue_valid = 0;
        issue_op = '0;
        issue_dst_tag = '0;
        issue_rob_tag = '0;
        issue_src1_ready = 0;
        issue_src1_tag = '0;
        issue_src1_value = '0;
        issue_src2_ready = 0;
        issue_src2_tag = '0;
        issue_src2_value = '0;
        cdb_valid = 0;
        cdb_tag = '0;
        cdb_value = '0;
        idle = '{default: '0};

        // Reset release, bounded
        n = 0;
        while (reset !== 1'b0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (reset !== 1'b0) begin
            $display("Reset was never released");
            $display("Some tests failed");
            $finish;
        end else begin
            @(negedge clk);
            check_bit("result_valid", result_valid, 1'b0);
            check_word("result_value", result_value, '0);
            check_flags("result_flags", result_flags, '0);
            check_tag("result_tag", result_tag, '0);
            check_rob("result_rob_tag", result_rob_tag, '0);
            $display("reset test %s", (errors == 0) ? "ok" : "FAILED");
            if (errors != 0)
                failed_tests++;

            load_table(rows);
            // Random rows reuse the table's ALU operations
            for (int k = 0; k < NUM_RANDOM; k++) begin
                r = idle;
                r.issue_valid = 1;
                r.op = rows[$urandom % NUM_TABLE_OPS].op;
                r.dst = preg_tag_t'($urandom);
                r.rob = rob_tag_t'($urandom);
                r.src1 = '{1'b1, 6'h0, word_t'($urandom)};
                r.src2 = '{1'b1, 6'h0, word_t'($urandom)};
                r.exp_ready = 1;
                r.exp_valid = 1;
                model_alu(r.op, r.src1.value, r.src2.value, r.exp_value, r.exp_flags);
                rows.push_back(r);
            end

            // Issue one row per cycle, check its result one edge later
            err_before = errors;
            for (int i = 0; i <= rows.size(); i++) begin
                @(posedge clk);
                drive_row((i < rows.size()) ? rows[i] : idle);
                @(negedge clk);
                if (i > 0) begin
                    check_result(rows[i-1]);
                    $display("test %0d %s", i - 1, (errors == err_before) ? "ok" : "FAILED");
                    if (errors != err_before)
                        failed_tests++;
                    err_before = errors;
                end
                if (i < rows.size())
                    check_bit("issue_ready", issue_ready, rows[i].exp_ready);
            end

            $display("tests %0d, failed %0d, errors %0d", rows.size() + 1, failed_tests,
                     errors);
            if (errors == 0)
                $display("All tests passed");
            else
                $display("Some tests failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD      = 100.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // Hold reset over the first edges
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: hdl/alu_exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

module alu_exec_unit
    import core_pkg::*;
#(
    parameter int XLEN   = core_pkg::XLEN,
    parameter int PHYS_W = core_pkg::LOG2_PREGS
) (
    input  logic              clk,
    input  logic              reset,
    // Issue port
    input  logic              issue_valid,
    input  alu_op_t           issue_op,
    input  logic [PHYS_W-1:0] issue_dst_tag,
    input  rob_tag_t          issue_rob_tag,
    input  logic              issue_src1_ready,
    input  logic [PHYS_W-1:0] issue_src1_tag,
    input  logic [XLEN-1:0]   issue_src1_value,
    input  logic              issue_src2_ready,
    input  logic [PHYS_W-1:0] issue_src2_tag,
    input  logic [XLEN-1:0]   issue_src2_value,
    output logic              issue_ready,
    // CDB snoop
    input  logic              cdb_valid,
    input  logic [PHYS_W-1:0] cdb_tag,
    input  logic [XLEN-1:0]   cdb_value,
    // Result toward CDB
    output logic              result_valid,
    output logic [PHYS_W-1:0] result_tag,
    output logic [XLEN-1:0]   result_value,
    output rob_tag_t          result_rob_tag,
    output alu_flags_t        result_flags
);

    src_operand_t src1;
    src_operand_t src2;

    // Pack plain source ports into descriptors
    assign src1 = '{ready: issue_src1_ready, tag: issue_src1_tag, value: issue_src1_value};
    assign src2 = '{ready: issue_src2_ready, tag: issue_src2_tag, value: issue_src2_value};

    // ==============================
    // Bypass stage to ALU
    // ==============================
    issue_if #(.XLEN(XLEN), .PHYS_W(PHYS_W)) i_issue ();

    // Registered ALU result loops back as the bypass source
    operand_bypass #(.XLEN(XLEN), .PHYS_W(PHYS_W)) i_operand_bypass (
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_dst_tag (issue_dst_tag),
        .issue_rob_tag (issue_rob_tag),
        .issue_src1    (src1),
        .issue_src2    (src2),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value),
        .fwd_valid     (result_valid),
        .fwd_tag       (result_tag),
        .fwd_value     (result_value),
        .issue_ready   (issue_ready),
        .out           (i_issue.producer)
    );

    alu #(.XLEN(XLEN), .PHYS_W(PHYS_W)) i_alu (
        .clk            (clk),
        .reset          (reset),
        .in             (i_issue.consumer),
        .result_valid   (result_valid),
        .result_tag     (result_tag),
        .result_value   (result_value),
        .result_rob_tag (result_rob_tag),
        .result_flags   (result_flags)
    );

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu
    import core_pkg::*;
#(
    parameter int XLEN   = core_pkg::XLEN,
    parameter int PHYS_W = core_pkg::LOG2_PREGS
) (
    input  logic              clk,
    input  logic              reset,
    issue_if.consumer         in,
    // Registered result, also the bypass source
    output logic              result_valid,
    output logic [PHYS_W-1:0] result_tag,
    output logic [XLEN-1:0]   result_value,
    output rob_tag_t          result_rob_tag,
    output alu_flags_t        result_flags
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic [XLEN-1:0]    a;
    logic [XLEN-1:0]    b;
    logic [SHAMT_W-1:0] shamt;
    // One extra bit for carry out / no-borrow
    logic [XLEN:0]      add_full;
    logic [XLEN:0]      sub_full;
    logic [XLEN-1:0]    res;
    logic               res_valid;
    logic               is_add;
    logic               is_sub;
    alu_flags_t         flags;

    assign a     = in.src1;
    assign b     = in.src2;
    assign shamt = b[SHAMT_W-1:0];

    assign add_full = {1'b0, a} + {1'b0, b};
    // a + ~b + 1, top bit set means no borrow
    assign sub_full = {1'b0, a} + {1'b0, ~b} + 1'b1;

    // ==============================
    // Decode and compute
    // ==============================
    always_comb begin
        res       = '0;
        res_valid = 1'b0;
        is_add    = 1'b0;
        is_sub    = 1'b0;
        if (in.valid) begin
            res_valid = 1'b1;
            case (in.op.opcode)
                OP_RTYPE: begin
                    case (in.op.func)
                        FN_ADD: begin
                            res    = add_full[XLEN-1:0];
                            is_add = 1'b1;
                        end
                        FN_SUB, FN_CMP: begin
                            res    = sub_full[XLEN-1:0];
                            is_sub = 1'b1;
                        end
                        FN_AND:          res = a & b;
                        FN_ORR:          res = a | b;
                        FN_EOR:          res = a ^ b;
                        FN_NEG:          res = '0 - a;
                        FN_LSL, FN_LSLI: res = a << shamt;
                        FN_LSR, FN_LSRI: res = a >> shamt;
                        // Return address passes through
                        FN_RET:          res = a;
                        // Unknown func still retires, as zero
                        default:         res = '0;
                    endcase
                end
                OP_ADDI: begin
                    res    = add_full[XLEN-1:0];
                    is_add = 1'b1;
                end
                OP_SUBI: begin
                    res    = sub_full[XLEN-1:0];
                    is_sub = 1'b1;
                end
                OP_ANDI: res = a & b;
                OP_ORI:  res = a | b;
                OP_EORI: res = a ^ b;
                // Not an ALU op, no CDB write
                default: res_valid = 1'b0;
            endcase
        end
    end

    // ==============================
    // Flags
    // ==============================
    always_comb begin
        flags          = '0;
        flags.zero     = (res == '0);
        flags.negative = res[XLEN-1];
        if (is_add) begin
            // Same-sign inputs, result sign flipped
            flags.overflow = (a[XLEN-1] == b[XLEN-1]) && (res[XLEN-1] != a[XLEN-1]);
            flags.carry    = add_full[XLEN];
        end else if (is_sub) begin
            flags.overflow = (a[XLEN-1] != b[XLEN-1]) && (res[XLEN-1] != a[XLEN-1]);
            flags.carry    = sub_full[XLEN];
        end
        // Nothing reported without a valid result
        if (!res_valid)
            flags = '0;
    end

    // ==============================
    // Result register
    // ==============================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result_valid   <= 1'b0;
            result_tag     <= '0;
            result_value   <= '0;
            result_rob_tag <= '0;
            result_flags   <= '0;
        end else begin
            result_valid   <= res_valid;
            result_tag     <= in.dst_tag;
            result_value   <= res;
            result_rob_tag <= in.rob_tag;
            result_flags   <= flags;
        end
    end

endmodule

`default_nettype wire

// File: hdl/operand_bypass.sv
`timescale 1ns/10ps
`default_nettype none

module operand_bypass
    import core_pkg::*;
#(
    parameter int XLEN   = core_pkg::XLEN,
    parameter int PHYS_W = core_pkg::LOG2_PREGS
) (
    // Issue from reservation station
    input  logic              issue_valid,
    input  alu_op_t           issue_op,
    input  logic [PHYS_W-1:0] issue_dst_tag,
    input  rob_tag_t          issue_rob_tag,
    input  src_operand_t      issue_src1,
    input  src_operand_t      issue_src2,
    // CDB snoop
    input  logic              cdb_valid,
    input  logic [PHYS_W-1:0] cdb_tag,
    input  logic [XLEN-1:0]   cdb_value,
    // ALU registered result, fed back
    input  logic              fwd_valid,
    input  logic [PHYS_W-1:0] fwd_tag,
    input  logic [XLEN-1:0]   fwd_value,
    output logic              issue_ready,
    issue_if.producer         out
);

    logic src1_fwd_hit, src1_cdb_hit;
    logic src2_fwd_hit, src2_cdb_hit;
    logic src1_ok, src2_ok;

    // Tag match only matters while the operand is still waiting
    function automatic logic tag_hit(input src_operand_t src, input logic valid,
                                     input logic [PHYS_W-1:0] tag);
        return !src.ready && valid && (src.tag == tag);
    endfunction

    // Carried value first, then ALU bypass, then CDB
    function automatic logic [XLEN-1:0] pick_value(input src_operand_t src,
                                                   input logic fwd_hit,
                                                   input logic cdb_hit,
                                                   input logic [XLEN-1:0] fwd_val,
                                                   input logic [XLEN-1:0] cdb_val);
        if (src.ready)
            return src.value;
        else if (fwd_hit)
            return fwd_val;
        else if (cdb_hit)
            return cdb_val;
        return src.value;
    endfunction

    // ==============================
    // Tag compare per source
    // ==============================
    assign src1_fwd_hit = tag_hit(issue_src1, fwd_valid, fwd_tag);
    assign src1_cdb_hit = tag_hit(issue_src1, cdb_valid, cdb_tag);
    assign src2_fwd_hit = tag_hit(issue_src2, fwd_valid, fwd_tag);
    assign src2_cdb_hit = tag_hit(issue_src2, cdb_valid, cdb_tag);

    assign src1_ok = issue_src1.ready || src1_fwd_hit || src1_cdb_hit;
    assign src2_ok = issue_src2.ready || src2_fwd_hit || src2_cdb_hit;

    // Accept only with both operands in hand
    assign issue_ready = src1_ok && src2_ok;

    // ==============================
    // Resolved instruction
    // ==============================
    assign out.valid   = issue_valid && issue_ready;
    assign out.op      = issue_op;
    assign out.dst_tag = issue_dst_tag;
    assign out.rob_tag = issue_rob_tag;
    assign out.src1    = pick_value(issue_src1, src1_fwd_hit, src1_cdb_hit,
                                    fwd_value, cdb_value);
    assign out.src2    = pick_value(issue_src2, src2_fwd_hit, src2_cdb_hit,
                                    fwd_value, cdb_value);

endmodule

`default_nettype wire

// File: hdl/issue_if.sv
`timescale 1ns/10ps
`default_nettype none

// One resolved instruction, operands already captured
interface issue_if
    import core_pkg::*;
#(
    parameter int XLEN   = core_pkg::XLEN,
    parameter int PHYS_W = core_pkg::LOG2_PREGS
) ();

    logic              valid;
    alu_op_t           op;
    logic [PHYS_W-1:0] dst_tag;
    rob_tag_t          rob_tag;
    // Operand words, no tags left at this point
    logic [XLEN-1:0]   src1;
    logic [XLEN-1:0]   src2;

    // Bypass stage side
    modport producer (
        output valid, op, dst_tag, rob_tag, src1, src2
    );

    // ALU side
    modport consumer (
        input valid, op, dst_tag, rob_tag, src1, src2
    );

endinterface

`default_nettype wire

// File: hdl/core_pkg.sv
`default_nettype none

package core_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int XLEN       = 32;
    localparam int LOG2_PREGS = 6;
    localparam int ROB_W      = 6;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [LOG2_PREGS-1:0] preg_tag_t;
    typedef logic [ROB_W-1:0]      rob_tag_t;

    // Opcode in the upper half, function code in the lower half
    typedef struct packed {
        logic [5:0] opcode;
        logic [5:0] func;
    } alu_op_t;

    // ==============================
    // Opcodes
    // ==============================
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_SUBI  = 6'b001001;
    localparam logic [5:0] OP_ANDI  = 6'b001010;
    localparam logic [5:0] OP_ORI   = 6'b001011;
    localparam logic [5:0] OP_EORI  = 6'b001100;

    // R-type function codes
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_ORR  = 6'b100101;
    localparam logic [5:0] FN_EOR  = 6'b100110;
    localparam logic [5:0] FN_NEG  = 6'b101000;
    localparam logic [5:0] FN_CMP  = 6'b101010;
    localparam logic [5:0] FN_LSL  = 6'b000000;
    localparam logic [5:0] FN_LSR  = 6'b000010;
    localparam logic [5:0] FN_LSLI = 6'b000001;
    localparam logic [5:0] FN_LSRI = 6'b000011;
    localparam logic [5:0] FN_RET  = 6'b111000;

    // ==============================
    // Shared structs
    // ==============================
    typedef struct packed {
        logic zero;
        logic negative;
        logic overflow;
        logic carry;
    } alu_flags_t;

    // Source operand as held in the reservation station
    typedef struct packed {
        logic      ready;
        preg_tag_t tag;
        word_t     value;
    } src_operand_t;

endpackage

`default_nettype wire
